/* Bender.yml */
package:
  name: squeeze_layer

sources:
  # Design
  - include_dirs:
      - logic
    files:
      - logic/squeeze_pkg.sv
      - logic/tap_ctrl_if.sv
      - logic/squeeze_wb_regs.sv
      - logic/squeeze_ctrl.sv
      - logic/tap_counter.sv
      - logic/mac_lane.sv
      - logic/bias_relu_quant.sv
      - logic/squeeze_layer.sv

  # Verification
  - target: test
    include_dirs:
      - logic
    files:
      - verif/squeeze_layer_checker.sv
      - verif/squeeze_layer_tb.sv

/* logic/bias_relu_quant.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module bias_relu_quant (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic signed [2*`SQ_WIDTH-1:0]     acc [`SQ_LANES],
	input  logic                              acc_valid,
	input  logic                              acc_last_pixel,
	input  logic signed [2*`SQ_WIDTH-1:0]     biases [`SQ_LANES],
	input  logic                              ofm_hold,
	output logic [`SQ_LANES*`SQ_WIDTH-1:0]    ofm,
	output logic                              ofm_valid,
	output logic                              out_fire_last
);

	logic signed [2*`SQ_WIDTH-1:0] sum [`SQ_LANES];
	logic [`SQ_LANES*`SQ_WIDTH-1:0] quant;
	logic ofm_last;

	// Bias, ReLU and Q-format truncation per lane
	always_comb begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			sum[l] = acc[l] + biases[l];
			if (sum[l][2*`SQ_WIDTH-1]) begin
				// Negative clamps to zero
				quant[l*`SQ_WIDTH +: `SQ_WIDTH] = '0;
			end else begin
				quant[l*`SQ_WIDTH +: `SQ_WIDTH] =
					{1'b0, sum[l][`SQ_FRAC+`SQ_WIDTH-2:`SQ_FRAC]};
			end
		end
	end

	// Output register, held while the consumer stalls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ofm <= '0;
			ofm_valid <= 1'b0;
			ofm_last <= 1'b0;
		end else if (!ofm_hold) begin
			ofm_valid <= acc_valid;
			if (acc_valid) begin
				ofm <= quant;
				ofm_last <= acc_last_pixel;
			end
		end
	end

	// Final pixel leaves the engine
	assign out_fire_last = ofm_valid && !ofm_hold && ofm_last;

endmodule

/* logic/mac_lane.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module mac_lane (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic signed [`SQ_WIDTH-1:0]   pix,
	input  logic signed [`SQ_WIDTH-1:0]   ker,
	tap_ctrl_if.datapath                  tap,
	output logic signed [2*`SQ_WIDTH-1:0] acc,
	output logic                          acc_valid,
	output logic                          acc_last_pixel
);

	logic signed [2*`SQ_WIDTH-1:0] prod;
	logic prod_valid;
	logic prod_first;
	logic prod_last;
	logic prod_last_pix;

	// Product stage, loaded on the accepting edge
	always_ff @(posedge clk) begin
		if (tap.advance) begin
			prod <= pix * ker;
		end
	end

	// Tags follow the product, frozen under hold
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
			prod_last_pix <= 1'b0;
		end else if (!tap.stall) begin
			prod_valid <= tap.advance;
			prod_first <= tap.first_tap;
			prod_last <= tap.last_tap;
			prod_last_pix <= tap.last_pixel;
		end
	end

	// Accumulator restarts on a first tap
	always_ff @(posedge clk) begin
		if (!tap.stall && prod_valid) begin
			acc <= prod_first ? prod : acc + prod;
		end
	end

	// Pixel sum ready one cycle after its last tap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
			acc_last_pixel <= 1'b0;
		end else if (!tap.stall) begin
			acc_valid <= prod_valid && prod_last;
			acc_last_pixel <= prod_valid && prod_last && prod_last_pix;
		end
	end

endmodule

/* logic/squeeze_ctrl.sv */
`timescale 1ns/100ps

module squeeze_ctrl import squeeze_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   ifm_valid,
	input  logic   ofm_hold,
	input  logic   out_fire_last,
	tap_ctrl_if.ctrl tap,
	output logic   ifm_ready,
	output logic   busy,
	output logic   done
);

	sq_state_e state;

	//////////////////////////////////////////////////
	// Handshake combination
	//////////////////////////////////////////////////

	// Accept only while running and the consumer is not holding
	assign ifm_ready = (state == RUN) && !ofm_hold;

	// One tap per accepting edge
	assign tap.advance = ifm_valid && ifm_ready;

	// Hold freezes the whole pipeline
	assign tap.stall = ofm_hold;

	// Status flags
	assign busy = (state == RUN) || (state == DRAIN);
	assign done = (state == DONE);

	//////////////////////////////////////////////////
	// Layer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE, DONE: begin
					// Restart also clears done
					if (start) begin
						state <= RUN;
					end
				end
				RUN: begin
					// Last tap of the last pixel taken
					if (tap.advance && tap.last_tap && tap.last_pixel) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					// Wait for the tagged result to be consumed
					if (out_fire_last) begin
						state <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* logic/squeeze_layer.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module squeeze_layer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [`SQ_WB_AW-1:0]           wb_adr,
	input  logic [31:0]                    wb_dat_w,
	output logic [31:0]                    wb_dat_r,
	output logic                           wb_ack,
	input  logic [`SQ_WIDTH-1:0]           ifm,
	input  logic                           ifm_valid,
	output logic                           ifm_ready,
	output logic [`SQ_LANES*`SQ_WIDTH-1:0] ofm,
	output logic                           ofm_valid,
	input  logic                           ofm_hold,
	output logic                           layer_done
);

	logic start;
	logic busy;
	logic out_fire_last;

	logic signed [`SQ_WIDTH-1:0] kernels [`SQ_LANES];
	logic signed [2*`SQ_WIDTH-1:0] biases [`SQ_LANES];
	logic signed [2*`SQ_WIDTH-1:0] lane_acc [`SQ_LANES];
	logic [`SQ_LANES-1:0] lane_valid;
	logic [`SQ_LANES-1:0] lane_last;

	// Tap advance, stall and position
	tap_ctrl_if tap_bus ();

	//////////////////////////////////////////////////
	// Host registers and control
	//////////////////////////////////////////////////

	squeeze_wb_regs regs_inst (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.busy(busy), .done(layer_done), .tap(tap_bus.datapath),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .start(start),
		.kernels(kernels), .biases(biases)
	);

	squeeze_ctrl ctrl_inst (
		.clk(clk), .rst_n(rst_n), .start(start),
		.ifm_valid(ifm_valid), .ofm_hold(ofm_hold),
		.out_fire_last(out_fire_last), .tap(tap_bus.ctrl),
		.ifm_ready(ifm_ready), .busy(busy), .done(layer_done)
	);

	tap_counter counter_inst (
		.clk(clk), .rst_n(rst_n), .start(start), .tap(tap_bus.counter)
	);

	//////////////////////////////////////////////////
	// MAC lanes and output stage
	//////////////////////////////////////////////////

	// Every lane sees the same pixel
	for (genvar i = 0; i < `SQ_LANES; i++) begin : lane_gen
		mac_lane lane_inst (
			.clk(clk), .rst_n(rst_n), .pix(ifm), .ker(kernels[i]),
			.tap(tap_bus.datapath), .acc(lane_acc[i]),
			.acc_valid(lane_valid[i]), .acc_last_pixel(lane_last[i])
		);
	end

	// Lanes run in lockstep, tags agree
	bias_relu_quant quant_inst (
		.clk(clk), .rst_n(rst_n), .acc(lane_acc),
		.acc_valid(&lane_valid), .acc_last_pixel(&lane_last),
		.biases(biases), .ofm_hold(ofm_hold),
		.ofm(ofm), .ofm_valid(ofm_valid), .out_fire_last(out_fire_last)
	);

endmodule

/* logic/squeeze_pkg.sv */
package squeeze_pkg;

	//////////////////////////////////////////////////
	// Layer controller states
	//////////////////////////////////////////////////

	// Waiting for the first start
	// RUN accepts taps, DRAIN waits for the last result
	// DONE holds the layer-done flag until the next start
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		DRAIN = 2'd2,
		DONE  = 2'd3
	} sq_state_e;

	//////////////////////////////////////////////////
	// Wishbone register map
	//////////////////////////////////////////////////

	// Decoded from the two top address bits
	// Lower address bits index words inside a region
	typedef enum logic [1:0] {
		// Bit 0 written high starts a layer
		REG_CTRL   = 2'd0,
		// Bit 0 busy, bit 1 done
		REG_STATUS = 2'd1,
		// One 32-bit signed bias per lane
		REG_BIAS   = 2'd2,
		// Index is tap times lanes plus lane
		REG_KERNEL = 2'd3
	} sq_reg_e;

endpackage

/* logic/squeeze_settings.svh */
`ifndef SQUEEZE_SETTINGS_SVH
`define SQUEEZE_SETTINGS_SVH

// Data width of pixels, kernel words and output words
`define SQ_WIDTH 16

// Parallel output channels, one MAC lane each
`define SQ_LANES 4

// Input channels and kernel side
`define SQ_CHIN 8
`define SQ_KDIM 1

// Taps per output pixel
`define SQ_TAPS (`SQ_KDIM * `SQ_KDIM * `SQ_CHIN)

// Output side, WOUT squared pixels per layer
`define SQ_WOUT 4

// Q-format fraction bits dropped at the output
`define SQ_FRAC 14

// Wishbone word address width
`define SQ_WB_AW 8

`endif

/* logic/squeeze_wb_regs.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module squeeze_wb_regs import squeeze_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [`SQ_WB_AW-1:0]              wb_adr,
	input  logic [31:0]                       wb_dat_w,
	input  logic                              busy,
	input  logic                              done,
	tap_ctrl_if.datapath                      tap,
	output logic [31:0]                       wb_dat_r,
	output logic                              wb_ack,
	output logic                              start,
	output logic signed [`SQ_WIDTH-1:0]       kernels [`SQ_LANES],
	output logic signed [2*`SQ_WIDTH-1:0]     biases [`SQ_LANES]
);

	localparam int KER_WORDS = `SQ_TAPS * `SQ_LANES;
	localparam int KER_AW = $clog2(KER_WORDS);
	localparam int LANE_AW = $clog2(`SQ_LANES);

	// Kernel words, tap major
	logic signed [`SQ_WIDTH-1:0] kernel_mem [KER_WORDS];

	sq_reg_e reg_sel;
	logic [`SQ_WB_AW-3:0] word_idx;
	logic req_new;
	logic wr_en;
	logic [31:0] rd_data;

	//////////////////////////////////////////////////
	// Address decode and handshake
	//////////////////////////////////////////////////

	assign reg_sel = sq_reg_e'(wb_adr[`SQ_WB_AW-1 -: 2]);
	assign word_idx = wb_adr[`SQ_WB_AW-3:0];

	// New request, not the cycle already acked
	assign req_new = wb_cyc && wb_stb && !wb_ack;
	assign wr_en = req_new && wb_we;

	// Start only from an idle engine
	assign start = wr_en && (reg_sel == REG_CTRL) && wb_dat_w[0] && !busy;

	// Single-cycle ack one clock after the request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req_new;
		end
	end

	//////////////////////////////////////////////////
	// Kernel and bias storage
	//////////////////////////////////////////////////

	// Frozen while a layer runs
	always_ff @(posedge clk) begin
		if (wr_en && !busy) begin
			if (reg_sel == REG_KERNEL && word_idx < KER_WORDS) begin
				kernel_mem[word_idx[KER_AW-1:0]] <= wb_dat_w[`SQ_WIDTH-1:0];
			end
			if (reg_sel == REG_BIAS && word_idx < `SQ_LANES) begin
				biases[word_idx[LANE_AW-1:0]] <= wb_dat_w;
			end
		end
	end

	// Kernel word of the next tap for every lane
	always_comb begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			kernels[l] = kernel_mem[KER_AW'(tap.tap_idx * `SQ_LANES + l)];
		end
	end

	//////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			REG_STATUS: rd_data = {30'b0, done, busy};
			REG_BIAS: begin
				if (word_idx < `SQ_LANES) begin
					rd_data = biases[word_idx[LANE_AW-1:0]];
				end
			end
			REG_KERNEL: begin
				// Sign extended to the bus width
				if (word_idx < KER_WORDS) begin
					rd_data = 32'(kernel_mem[word_idx[KER_AW-1:0]]);
				end
			end
			default: rd_data = '0;
		endcase
	end

	// Read data lands with ack
	always_ff @(posedge clk) begin
		if (req_new && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

/* logic/tap_counter.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module tap_counter (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	tap_ctrl_if.counter tap
);

	localparam int PIXELS = `SQ_WOUT * `SQ_WOUT;
	localparam int TAP_W = $clog2(`SQ_TAPS);
	localparam int PIX_W = $clog2(PIXELS);

	localparam logic [TAP_W-1:0] TAP_LAST = TAP_W'(`SQ_TAPS - 1);
	localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(PIXELS - 1);

	logic [TAP_W-1:0] tap_cnt;
	logic [PIX_W-1:0] pix_cnt;

	//////////////////////////////////////////////////
	// Tap and pixel counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap_cnt <= '0;
			pix_cnt <= '0;
		end else if (start) begin
			// Fresh layer
			tap_cnt <= '0;
			pix_cnt <= '0;
		end else if (tap.advance) begin
			if (tap_cnt == TAP_LAST) begin
				// Pixel complete, wrap taps
				tap_cnt <= '0;
				if (pix_cnt == PIX_LAST) begin
					pix_cnt <= '0;
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// Position of the next tap to be accepted
	assign tap.tap_idx = tap_cnt;
	assign tap.first_tap = (tap_cnt == '0);
	assign tap.last_tap = (tap_cnt == TAP_LAST);
	assign tap.last_pixel = (pix_cnt == PIX_LAST);

endmodule

/* logic/tap_ctrl_if.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

interface tap_ctrl_if;

	localparam int TAP_W = $clog2(`SQ_TAPS);

	// Tap accepted at this edge
	logic advance;
	// Consumer hold, freezes the datapath
	logic stall;

	// Describe the tap that will be accepted next
	logic [TAP_W-1:0] tap_idx;
	logic first_tap;
	logic last_tap;
	logic last_pixel;

	// Controller issues advance and stall
	modport ctrl (output advance, output stall, input last_tap, input last_pixel);

	// Counter follows advance and reports position
	modport counter (input advance, output tap_idx, output first_tap,
		output last_tap, output last_pixel);

	// Lanes and kernel storage only observe
	modport datapath (input advance, input stall, input tap_idx, input first_tap,
		input last_tap, input last_pixel);

endinterface

/* verif/squeeze_layer_checker.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module squeeze_layer_checker import squeeze_pkg::*; (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           wb_cyc,
	input logic                           wb_stb,
	input logic                           wb_ack,
	input logic                           ifm_ready,
	input logic [`SQ_LANES*`SQ_WIDTH-1:0] ofm,
	input logic                           ofm_valid,
	input logic                           ofm_hold,
	input logic                           layer_done,
	input sq_state_e                      state
);

	//////////////////////////////////////////////////
	// Wishbone slave
	//////////////////////////////////////////////////

	// Ack only inside a request
	ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> wb_cyc && wb_stb) else $error("ack outside a request");

	// Single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack) else $error("ack high on two cycles in a row");

	//////////////////////////////////////////////////
	// Stream handshakes
	//////////////////////////////////////////////////

	// Held result frozen
	held_output_stable: assert property (@(posedge clk) disable iff (!rst_n)
		ofm_valid && ofm_hold |=> ofm_valid && $stable(ofm))
		else $error("ofm changed while held");

	// Input taken only in RUN without hold
	ready_only_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		ifm_ready |-> !ofm_hold && state == RUN)
		else $error("ifm_ready high outside RUN or under hold");

	ready_not_when_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(layer_done && ifm_ready)) else $error("ifm_ready high with layer_done");

	// ReLU output never has its sign bit set
	for (genvar l = 0; l < `SQ_LANES; l++) begin : lane_sign_gen
		top_bit_zero: assert property (@(posedge clk) disable iff (!rst_n)
			!ofm[l*`SQ_WIDTH + `SQ_WIDTH-1]) else $error("lane output top bit set");
	end

endmodule

bind squeeze_layer squeeze_layer_checker checker_inst (
	.clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.ifm_ready(ifm_ready), .ofm(ofm), .ofm_valid(ofm_valid), .ofm_hold(ofm_hold),
	.layer_done(layer_done), .state(ctrl_inst.state)
);

/* verif/squeeze_layer_tb.sv */
`timescale 1ns/100ps
`include "squeeze_settings.svh"

module squeeze_layer_tb import squeeze_pkg::*;;

	localparam int PIXELS = `SQ_WOUT * `SQ_WOUT;
	localparam int TAPS = `SQ_TAPS;
	localparam int LANES = `SQ_LANES;
	localparam int W = `SQ_WIDTH;
	localparam int OFM_W = LANES * W;
	localparam int AW = `SQ_WB_AW;
	// Four layers of 128 taps slowed by gaps and holds, plus about 200 bus transfers
	localparam int TIMEOUT_CYCLES = 3000;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [AW-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [W-1:0] ifm;
	logic ifm_valid;
	logic ifm_ready;
	logic [OFM_W-1:0] ofm;
	logic ofm_valid;
	logic ofm_hold;
	logic layer_done;

	// Reference data and expected results
	int ker [TAPS][LANES];
	int bias [LANES];
	int pix [PIXELS*TAPS];
	logic [OFM_W-1:0] exp_ofm [PIXELS];
	int clamp_cnt;
	int trunc_cnt;
	int seed;
	int cycle_cnt;
	string test_name;

	squeeze_layer squeeze_layer_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Cycle limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		fail_run("Timeout: the run did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else fail_run($sformatf("Error %s %s: expected %h actual %h",
			test_name, what, exp, got));
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else fail_run(msg);
	endtask

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	function automatic logic [AW-1:0] reg_adr(input sq_reg_e r, input int idx);
		return {r, (AW-2)'(idx)};
	endfunction

	// Holds the request until ack and drops it one edge later
	task automatic wb_access(input logic we, input logic [AW-1:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		rdata = wb_dat_r;
		@(posedge clk);
		#10;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [AW-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [AW-1:0] adr, output logic [31:0] rdata);
		wb_access(1'b0, adr, 32'd0, rdata);
	endtask

	//////////////////////////////////////////////////
	// Stimulus and model
	//////////////////////////////////////////////////

	// Random weights followed by a readback of every word
	task automatic load_weights();
		logic [31:0] rd;
		for (int t = 0; t < TAPS; t++) begin
			for (int l = 0; l < LANES; l++) begin
				ker[t][l] = $random(seed) % 16384;
				wb_write(reg_adr(REG_KERNEL, t*LANES + l), ker[t][l]);
			end
		end
		for (int l = 0; l < LANES; l++) begin
			bias[l] = $random(seed) % (1 << 27);
			wb_write(reg_adr(REG_BIAS, l), bias[l]);
		end
		for (int t = 0; t < TAPS; t++) begin
			for (int l = 0; l < LANES; l++) begin
				wb_read(reg_adr(REG_KERNEL, t*LANES + l), rd);
				check_value("kernel readback", $unsigned(ker[t][l]), rd);
			end
		end
		for (int l = 0; l < LANES; l++) begin
			wb_read(reg_adr(REG_BIAS, l), rd);
			check_value("bias readback", $unsigned(bias[l]), rd);
		end
	endtask

	task automatic gen_pixels();
		for (int i = 0; i < PIXELS*TAPS; i++) begin
			pix[i] = $random(seed) % 4096;
		end
	endtask

	// Dot product plus bias through ReLU and Q-format truncation
	task automatic build_model();
		logic signed [31:0] acc;
		logic signed [31:0] sum;
		clamp_cnt = 0;
		trunc_cnt = 0;
		for (int p = 0; p < PIXELS; p++) begin
			for (int l = 0; l < LANES; l++) begin
				acc = 0;
				for (int t = 0; t < TAPS; t++) begin
					acc = acc + pix[p*TAPS + t] * ker[t][l];
				end
				sum = acc + bias[l];
				if (sum < 0) begin
					exp_ofm[p][l*W +: W] = '0;
					clamp_cnt++;
				end else begin
					// Integer part of the Q value, kept to the 15 magnitude bits
					exp_ofm[p][l*W +: W] = W'((sum / (1 << `SQ_FRAC)) % (1 << (W-1)));
					if (sum % (1 << `SQ_FRAC) != 0) begin
						trunc_cnt++;
					end
				end
			end
		end
	endtask

	// Pixel stream with optional random gaps
	task automatic feed_layer(input int gap_pct);
		int idx;
		logic fire;
		idx = 0;
		while (idx < PIXELS*TAPS) begin
			ifm = pix[idx];
			ifm_valid = 1'b1;
			if (gap_pct > 0) begin
				ifm_valid = ($unsigned($random(seed)) % 100) >= gap_pct;
			end
			@(negedge clk);
			fire = ifm_valid && ifm_ready;
			@(posedge clk);
			#10;
			if (fire) begin
				idx++;
			end
		end
		ifm_valid = 1'b0;
	endtask

	// Consumer with optional hold pulses and a few forced holds on the last pixel
	task automatic collect_layer(input int hold_pct);
		int n;
		int last_holds;
		logic held;
		logic [OFM_W-1:0] held_ofm;
		n = 0;
		last_holds = 0;
		held = 1'b0;
		held_ofm = '0;
		while (n < PIXELS) begin
			ofm_hold = 1'b0;
			if (hold_pct > 0) begin
				ofm_hold = ($unsigned($random(seed)) % 100) < hold_pct;
				if (n == PIXELS-1 && ofm_valid && last_holds < 3) begin
					ofm_hold = 1'b1;
					last_holds++;
				end
			end
			@(negedge clk);
			if (held) begin
				check_true(ofm_valid, "ofm_valid dropped while held");
				check_value("held ofm", held_ofm, ofm);
			end
			check_true(!layer_done, "layer_done rose before the last result was consumed");
			held = ofm_valid && ofm_hold;
			held_ofm = ofm;
			if (ofm_valid && !ofm_hold) begin
				check_value($sformatf("pixel %0d", n), exp_ofm[n], ofm);
				n++;
			end
			@(posedge clk);
			#10;
		end
		ofm_hold = 1'b0;
	endtask

	// Bias write during a run must not land
	task automatic poke_bias_busy();
		logic [31:0] rd;
		repeat (20) @(posedge clk);
		#10;
		wb_read(reg_adr(REG_STATUS, 0), rd);
		check_true(rd[0], "engine not busy during the bias write");
		wb_write(reg_adr(REG_BIAS, 0), ~bias[0]);
	endtask

	task automatic run_layer(input int gap_pct, input int hold_pct, input bit busy_write);
		logic [31:0] rd;
		wb_write(reg_adr(REG_CTRL, 0), 32'd1);
		fork
			feed_layer(gap_pct);
			collect_layer(hold_pct);
			begin
				if (busy_write) begin
					poke_bias_busy();
				end
			end
		join
		@(negedge clk);
		check_true(layer_done, "layer_done low after the last result was consumed");
		check_true(!ofm_valid, "an extra result appeared after the last pixel");
		@(posedge clk);
		#10;
		wb_read(reg_adr(REG_STATUS, 0), rd);
		check_value("status after layer", 64'h2, {32'b0, rd});
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		seed = 88678;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		ifm = '0;
		ifm_valid = 1'b0;
		ofm_hold = 1'b0;
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// Reset values and register readback
		test_name = "reset";
		@(negedge clk);
		check_true(!wb_ack && !ifm_ready && !ofm_valid && !layer_done,
			"outputs not low after reset");
		@(posedge clk);
		#10;
		wb_read(reg_adr(REG_STATUS, 0), rd);
		check_value("status after reset", 64'h0, {32'b0, rd});
		load_weights();

		// Back to back stream
		test_name = "full layer";
		gen_pixels();
		build_model();
		check_true(clamp_cnt > 0, "random data gave no negative sum");
		check_true(trunc_cnt > 0, "random data gave no truncated positive sum");
		run_layer(0, 0, 1'b0);

		// Same data with a sparse input
		test_name = "input gaps";
		run_layer(40, 0, 1'b0);

		test_name = "output hold";
		run_layer(0, 30, 1'b0);

		// New weights and a bias write attempted mid-run
		test_name = "restart";
		load_weights();
		gen_pixels();
		build_model();
		run_layer(0, 0, 1'b1);
		wb_read(reg_adr(REG_BIAS, 0), rd);
		check_value("bias after busy write", $unsigned(bias[0]), rd);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/squeeze_pkg.sv
logic/tap_ctrl_if.sv
logic/squeeze_wb_regs.sv
logic/squeeze_ctrl.sv
logic/tap_counter.sv
logic/mac_lane.sv
logic/bias_relu_quant.sv
logic/squeeze_layer.sv
verif/squeeze_layer_checker.sv
verif/squeeze_layer_tb.sv
